//--- aluPkg.sv
package aluPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Rename tag. Zero never names a producer.
    typedef logic [3:0] tag_t;

    typedef enum logic [4:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } aluOp_t;

    // Source operand, either a value or the tag of its pending producer.
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t data;
    } operand_t;

    typedef struct packed {
        aluOp_t   op;
        addr_t    pc;
        word_t    imm;
        tag_t     rd;
        operand_t src1;
        operand_t src2;
    } dispatch_t;

    typedef struct packed {
        aluOp_t op;
        addr_t  pc;
        word_t  imm;
        tag_t   rd;
        word_t  rs1Data;
        word_t  rs2Data;
    } issue_t;

    // Result broadcast. Jump is the branch-taken flag.
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
        logic  jump;
        addr_t target;
    } cdb_t;

endpackage

//--- aluReservationStation.sv
`timescale 1ns/1ps

module aluReservationStation
    import aluPkg::*;
#(
    parameter int RsDepth = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,
    input  dispatch_t dispatch,
    input  logic      dispatchValid,
    output logic      dispatchReady,
    input  cdb_t      cdb,
    output issue_t    issue,
    output logic      issueValid
);

    localparam int IdxW = (RsDepth > 1) ? $clog2(RsDepth) : 1;

    logic [RsDepth-1:0] busy;
    dispatch_t          slots [RsDepth];
    logic [RsDepth-1:0] readyVec;
    logic [IdxW-1:0]    issueIdx;
    logic [IdxW-1:0]    freeIdx;
    logic               freeFound;
    logic               accept;
    logic               issueFire;
    dispatch_t          newEntry;

    // Capture a waiting operand when its producer broadcasts.
    function automatic operand_t snoop(operand_t opnd, cdb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.data  = bus.data;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < RsDepth; i++) begin
            readyVec[i] = busy[i] && slots[i].src1.ready && slots[i].src2.ready;
        end
    end

    // Lowest ready entry issues.
    always_comb begin
        issueIdx = '0;
        for (int i = RsDepth - 1; i >= 0; i--) begin
            if (readyVec[i]) begin
                issueIdx = IdxW'(i);
            end
        end
    end

    // Lowest free entry takes the next dispatch.
    always_comb begin
        freeIdx   = '0;
        freeFound = 1'b0;
        for (int i = RsDepth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                freeIdx   = IdxW'(i);
                freeFound = 1'b1;
            end
        end
    end

    // Operands broadcast in the dispatch cycle count as ready.
    always_comb begin
        newEntry      = dispatch;
        newEntry.src1 = snoop(dispatch.src1, cdb);
        newEntry.src2 = snoop(dispatch.src2, cdb);
    end

    assign dispatchReady = freeFound;
    assign accept        = dispatchValid && dispatchReady && rdy;
    assign issueValid    = |readyVec;
    assign issueFire     = issueValid && rdy;

    always_comb begin
        issue.op      = slots[issueIdx].op;
        issue.pc      = slots[issueIdx].pc;
        issue.imm     = slots[issueIdx].imm;
        issue.rd      = slots[issueIdx].rd;
        issue.rs1Data = slots[issueIdx].src1.data;
        issue.rs2Data = slots[issueIdx].src2.data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else if (rdy) begin
            if (issueFire) begin
                busy[issueIdx] <= 1'b0;
            end
            if (accept) begin
                busy[freeIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            for (int i = 0; i < RsDepth; i++) begin
                if (busy[i]) begin
                    slots[i].src1 <= snoop(slots[i].src1, cdb);
                    slots[i].src2 <= snoop(slots[i].src2, cdb);
                end
            end
            if (accept) begin
                slots[freeIdx] <= newEntry;
            end
        end
    end

    // An entry leaves only when it is occupied and both operands are in.
    issueReadyCheck: assert property (
        @(posedge clk) disable iff (rst)
        issueValid |-> busy[issueIdx] && slots[issueIdx].src1.ready
                       && slots[issueIdx].src2.ready
    );

endmodule

//--- aluExecute.sv
`timescale 1ns/1ps

module aluExecute
    import aluPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  issue_t issue,
    input  logic   issueValid,
    output cdb_t   exResult
);

    word_t      rs1;
    word_t      rs2;
    word_t      imm;
    addr_t      pcPlus4;
    addr_t      pcPlusImm;
    logic [4:0] shamtReg;
    logic [4:0] shamtImm;
    logic       taken;
    cdb_t       nextResult;
    cdb_t       resPayload;
    logic       resValid;

    assign rs1       = issue.rs1Data;
    assign rs2       = issue.rs2Data;
    assign imm       = issue.imm;
    assign pcPlus4   = issue.pc + 32'd4;
    assign pcPlusImm = issue.pc + issue.imm;
    assign shamtReg  = rs2[4:0];
    assign shamtImm  = imm[4:0];

    // Branch decision.
    always_comb begin
        case (issue.op)
            BEQ:     taken = (rs1 == rs2);
            BNE:     taken = (rs1 != rs2);
            BLT:     taken = ($signed(rs1) < $signed(rs2));
            BGE:     taken = ($signed(rs1) >= $signed(rs2));
            BLTU:    taken = (rs1 < rs2);
            BGEU:    taken = (rs1 >= rs2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        nextResult       = '0;
        nextResult.valid = issueValid;
        nextResult.tag   = issue.rd;
        case (issue.op)
            LUI:   nextResult.data = imm;
            AUIPC: nextResult.data = pcPlusImm;
            JAL: begin
                nextResult.data   = pcPlus4;
                nextResult.jump   = 1'b1;
                nextResult.target = pcPlusImm;
            end
            JALR: begin
                nextResult.data   = pcPlus4;
                nextResult.jump   = 1'b1;
                nextResult.target = (rs1 + imm) & ~32'd1;
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                nextResult.jump   = taken;
                nextResult.target = taken ? pcPlusImm : pcPlus4;
            end
            ADDI:  nextResult.data = rs1 + imm;
            SLTI:  nextResult.data = word_t'($signed(rs1) < $signed(imm));
            SLTIU: nextResult.data = word_t'(rs1 < imm);
            XORI:  nextResult.data = rs1 ^ imm;
            ORI:   nextResult.data = rs1 | imm;
            ANDI:  nextResult.data = rs1 & imm;
            SLLI:  nextResult.data = rs1 << shamtImm;
            SRLI:  nextResult.data = rs1 >> shamtImm;
            SRAI:  nextResult.data = word_t'($signed(rs1) >>> shamtImm);
            ADD:   nextResult.data = rs1 + rs2;
            SUB:   nextResult.data = rs1 - rs2;
            SLL:   nextResult.data = rs1 << shamtReg;
            SLT:   nextResult.data = word_t'($signed(rs1) < $signed(rs2));
            SLTU:  nextResult.data = word_t'(rs1 < rs2);
            XOR:   nextResult.data = rs1 ^ rs2;
            SRL:   nextResult.data = rs1 >> shamtReg;
            SRA:   nextResult.data = word_t'($signed(rs1) >>> shamtReg);
            OR:    nextResult.data = rs1 | rs2;
            AND:   nextResult.data = rs1 & rs2;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else if (rdy) begin
            resValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueValid) begin
            resPayload <= nextResult;
        end
    end

    always_comb begin
        exResult       = resPayload;
        exResult.valid = resValid;
    end

    // The station frees an entry on issue, so one tag never executes twice in a row.
    tagRepeatCheck: assert property (
        @(posedge clk) disable iff (rst)
        exResult.valid && rdy |=> !exResult.valid || exResult.tag != $past(exResult.tag)
    );

endmodule

//--- cdbArbiter.sv
`timescale 1ns/1ps

module cdbArbiter
    import aluPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  cdb_t exResult,
    input  cdb_t load,
    output logic loadReady,
    output cdb_t cdb
);

    logic cdbValid;
    cdb_t cdbPayload;
    logic loadWin;

    // ALU always wins. A load waits upstream.
    assign loadReady = !exResult.valid;
    assign loadWin   = load.valid && loadReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdbValid <= 1'b0;
        end else if (rdy) begin
            cdbValid <= exResult.valid || loadWin;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (exResult.valid) begin
                cdbPayload <= exResult;
            end else if (loadWin) begin
                cdbPayload      <= load;
                cdbPayload.jump <= 1'b0;
            end
        end
    end

    always_comb begin
        cdb       = cdbPayload;
        cdb.valid = cdbValid;
    end

    // Tag zero is reserved.
    cdbTagCheck: assert property (
        @(posedge clk) disable iff (rst)
        cdb.valid |-> cdb.tag != '0
    );

endmodule

//--- aluCluster.sv
`timescale 1ns/1ps

module aluCluster
    import aluPkg::*;
#(
    parameter int RsDepth = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,
    input  dispatch_t dispatch,
    input  logic      dispatchValid,
    output logic      dispatchReady,
    input  cdb_t      load,
    output logic      loadReady,
    output cdb_t      cdb
);

    issue_t issue;
    logic   issueValid;
    cdb_t   exResult;

    // The station snoops the same registered bus the cluster drives.
    aluReservationStation #(
        .RsDepth(RsDepth)
    ) rs_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .dispatch     (dispatch),
        .dispatchValid(dispatchValid),
        .dispatchReady(dispatchReady),
        .cdb          (cdb),
        .issue        (issue),
        .issueValid   (issueValid)
    );

    aluExecute ex_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .issue     (issue),
        .issueValid(issueValid),
        .exResult  (exResult)
    );

    cdbArbiter arb_i (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .exResult (exResult),
        .load     (load),
        .loadReady(loadReady),
        .cdb      (cdb)
    );

endmodule

//--- tbAluCluster.sv
`timescale 1ns/1ps

module tbAluCluster
    import aluPkg::*;
;

    typedef struct packed {
        aluOp_t op;
        addr_t  pc;
        word_t  imm;
        tag_t   rd;
        tag_t   tag1;
        word_t  val1;
        tag_t   tag2;
        word_t  val2;
        cdb_t   exp;
    } entry_t;

    logic clk = 1'b0;
    logic rst;
    logic rdy;
    dispatch_t dispatch;
    logic dispatchValid;
    logic dispatchReady;
    cdb_t load;
    logic loadReady;
    cdb_t cdb;

    entry_t table_q[$];
    word_t  tagVal [16];
    logic   pending [16];
    cdb_t   expTag [16];
    logic [31:0] seed = 32'hb5a96bc0;
    logic   built = 1'b0;
    logic   fullSeen = 1'b0;
    logic   dispGo = 1'b0;
    logic   loadGo = 1'b0;
    int     dispIdx = 0;
    int     loadIdx = 0;
    int     outstanding = 0;
    tag_t   nextRd = 4'd1;

    aluCluster #(.RsDepth(4)) dut_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .dispatch     (dispatch),
        .dispatchValid(dispatchValid),
        .dispatchReady(dispatchReady),
        .load         (load),
        .loadReady    (loadReady),
        .cdb          (cdb)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Reference of the execute rules.
    function automatic cdb_t modelResult(aluOp_t op, addr_t pc, word_t imm, word_t a, word_t b);
        cdb_t r;
        logic br;
        word_t sum;
        r = '0;
        r.valid = 1'b1;
        br = 1'b0;
        sum = a + imm;
        case (op)
            BEQ:  br = a == b;
            BNE:  br = a != b;
            BLT:  br = $signed(a) < $signed(b);
            BGE:  br = !($signed(a) < $signed(b));
            BLTU: br = a < b;
            BGEU: br = !(a < b);
            default: br = 1'b0;
        endcase
        case (op)
            LUI:   r.data = imm;
            AUIPC: r.data = pc + imm;
            JAL: begin
                r.data = pc + 4;
                r.jump = 1'b1;
                r.target = pc + imm;
            end
            JALR: begin
                r.data = pc + 4;
                r.jump = 1'b1;
                r.target = {sum[31:1], 1'b0};
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                r.jump = br;
                r.target = br ? pc + imm : pc + 4;
            end
            ADDI:  r.data = sum;
            SLTI:  r.data = {31'd0, $signed(a) < $signed(imm)};
            SLTIU: r.data = {31'd0, a < imm};
            XORI:  r.data = a ^ imm;
            ORI:   r.data = a | imm;
            ANDI:  r.data = a & imm;
            SLLI:  r.data = a << imm[4:0];
            SRLI:  r.data = a >> imm[4:0];
            SRAI:  r.data = $signed(a) >>> imm[4:0];
            ADD:   r.data = a + b;
            SUB:   r.data = a - b;
            SLL:   r.data = a << b[4:0];
            SLT:   r.data = {31'd0, $signed(a) < $signed(b)};
            SLTU:  r.data = {31'd0, a < b};
            XOR:   r.data = a ^ b;
            SRL:   r.data = a >> b[4:0];
            SRA:   r.data = $signed(a) >>> b[4:0];
            OR:    r.data = a | b;
            AND:   r.data = a & b;
            default: ;
        endcase
        return r;
    endfunction

    // Tag sources resolve to the latest earlier producer in table order.
    task automatic addEntry(aluOp_t op, addr_t pc, word_t imm, tag_t rd,
                            tag_t t1, word_t v1, tag_t t2, word_t v2);
        entry_t e;
        e.op = op;
        e.pc = pc;
        e.imm = imm;
        e.rd = rd;
        e.tag1 = t1;
        e.tag2 = t2;
        e.val1 = (t1 != 0) ? tagVal[t1] : v1;
        e.val2 = (t2 != 0) ? tagVal[t2] : v2;
        e.exp = modelResult(op, pc, imm, e.val1, e.val2);
        e.exp.tag = rd;
        tagVal[rd] = e.exp.data;
        table_q.push_back(e);
    endtask

    task automatic checkCdb(cdb_t got, cdb_t exp);
        if (got !== exp) begin
            $display("ERR %0t: tag %0d gave data %h jump %b target %h, expected %h %b %h",
                     $time, got.tag, got.data, got.jump, got.target,
                     exp.data, exp.jump, exp.target);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    initial begin
        wait (built);
        repeat (40 * table_q.size() + 100) @(posedge clk);
        $display("Timeout: not every expected result reached the CDB in time.");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        word_t a;
        word_t b;
        addr_t pc;
        entry_t e;
        rst = 1'b1;
        rdy = 1'b1;
        dispatch = '0;
        dispatchValid = 1'b0;
        load = '0;
        for (int t = 0; t < 16; t++) begin
            pending[t] = 1'b0;
            tagVal[t] = '0;
        end
        tagVal[13] = 32'hdeadbeef;
        tagVal[14] = 32'h80000001;
        tagVal[15] = 32'h00000007;
        for (int t = 13; t < 16; t++) begin
            pending[t] = 1'b1;
            expTag[t] = {1'b1, tag_t'(t), tagVal[t], 1'b0, 32'd0};
        end
        outstanding = 3;
        // These four all wait on loads so the station fills.
        addEntry(ADD, 32'h100, 0, 4'd1, 4'd13, 0, 4'd14, 0);
        addEntry(SUB, 32'h104, 0, 4'd2, 4'd1, 0, 4'd15, 0);
        addEntry(SLL, 32'h108, 0, 4'd3, 0, 32'h1, 4'd15, 0);
        addEntry(BLT, 32'h10c, 32'hffffff80, 4'd4, 4'd14, 0, 4'd13, 0);
        addEntry(JALR, 32'h110, 32'h3, 4'd5, 4'd2, 0, 0, 0);
        addEntry(XOR, 32'h114, 0, 4'd6, 4'd3, 0, 4'd5, 0);
        nextRd = 4'd7;
        for (int pass = 0; pass < 5; pass++) begin
            for (int k = 0; k < 29; k++) begin
                seed = xorshift(seed);
                pc = seed & 32'hfffffffc;
                seed = xorshift(seed);
                a = seed;
                seed = xorshift(seed);
                b = seed;
                case (pass)
                    0: begin
                        a = 32'h80000000;
                        b = 32'h80000000;
                    end
                    1: begin
                        a = 32'h80000000;
                        b = 32'h00000001;
                    end
                    2: begin
                        a = 32'h00000001;
                        b = 32'h80000000;
                    end
                    3: begin
                        a = 32'hf00000f5;
                        b = 32'hffffffe1;
                    end
                    default: ;
                endcase
                if (k % 4 == 3 && pass == 4) begin
                    addEntry(aluOp_t'(k[4:0]), pc, b, nextRd,
                             nextRd == 4'd1 ? 4'd12 : nextRd - 4'd1, 0, 0, b);
                end else begin
                    addEntry(aluOp_t'(k[4:0]), pc, b, nextRd, 0, a, 0, b);
                end
                nextRd = (nextRd == 4'd12) ? 4'd1 : nextRd + 4'd1;
            end
        end
        built = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkFlag("dispatchReady after reset", dispatchReady, 1'b1);
        checkFlag("loadReady after reset", loadReady, 1'b1);
        checkFlag("cdb.valid after reset", cdb.valid, 1'b0);
        while (!(dispIdx == table_q.size() && loadIdx == 3 && outstanding == 0)) begin
            @(negedge clk);
            if (dispGo) begin
                e = table_q[dispIdx];
                pending[e.rd] = 1'b1;
                expTag[e.rd] = e.exp;
                outstanding++;
                dispIdx++;
            end
            // An accepted load is on the CDB right after the edge.
            if (loadGo) begin
                checkCdb(cdb, expTag[13 + loadIdx]);
                loadIdx++;
            end
            if (!dispatchReady) begin
                fullSeen = 1'b1;
            end
            seed = xorshift(seed);
            rdy = seed[2:0] != 3'd0;
            if (dispIdx < table_q.size()) begin
                e = table_q[dispIdx];
                dispatchValid = (dispatchValid && !dispGo)
                                || (seed[4:3] != 2'd0 && !pending[e.rd]);
                dispatch.op = e.op;
                dispatch.pc = e.pc;
                dispatch.imm = e.imm;
                dispatch.rd = e.rd;
                dispatch.src1.ready = e.tag1 == 0 || !pending[e.tag1];
                dispatch.src1.tag = e.tag1;
                dispatch.src1.data = dispatch.src1.ready ? e.val1 : '0;
                dispatch.src2.ready = e.tag2 == 0 || !pending[e.tag2];
                dispatch.src2.tag = e.tag2;
                dispatch.src2.data = dispatch.src2.ready ? e.val2 : '0;
            end else begin
                dispatchValid = 1'b0;
            end
            if (loadIdx < 3 && dispIdx >= 4) begin
                load.valid = (load.valid && !loadGo) || seed[5];
                load.tag = tag_t'(13 + loadIdx);
                load.data = tagVal[13 + loadIdx];
            end else begin
                load.valid = 1'b0;
            end
            if (cdb.valid && rdy) begin
                if (!pending[cdb.tag]) begin
                    $display("CDB carried tag %0d that had no pending result at %0t.",
                             cdb.tag, $time);
                    $display("TEST RESULT: FAIL");
                    $fatal(1);
                end
                checkCdb(cdb, expTag[cdb.tag]);
                pending[cdb.tag] = 1'b0;
                outstanding--;
            end
            dispGo = dispatchValid && dispatchReady && rdy;
            loadGo = load.valid && loadReady && rdy;
        end
        if (!fullSeen) begin
            $display("dispatchReady never dropped while the station was full.");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- build.f
aluPkg.sv
aluReservationStation.sv
aluExecute.sv
cdbArbiter.sv
aluCluster.sv
tbAluCluster.sv

//--- run.sh
#!/bin/sh
# Build and run the ALU cluster simulation with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbAluCluster -f build.f || exit 1
./obj_dir/VtbAluCluster | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
